// ==== verilog/periph_pkg.sv ====
package periph_pkg;

  // bus widths
  localparam int DATA_W   = 32;
  localparam int ADDR_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int OFFSET_W = 4;

  // slave map, 64 KiB windows
  localparam int NUM_SLAVES = 3;
  localparam int SLV_GPIO   = 0;
  localparam int SLV_TIMER  = 1;
  localparam int SLV_INTC   = 2;

  localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h44A4_0000;
  localparam logic [ADDR_W-1:0] INTC_BASE  = 32'h4180_0000;
  localparam logic [ADDR_W-1:0] WIN_MASK   = 32'hFFFF_0000;

  // register offsets
  localparam logic [OFFSET_W-1:0] GPIO_DATA_OFS   = 4'h0;
  localparam logic [OFFSET_W-1:0] GPIO_TRI_OFS    = 4'h4;
  localparam logic [OFFSET_W-1:0] TMR_LOAD_OFS    = 4'h0;
  localparam logic [OFFSET_W-1:0] TMR_CTRL_OFS    = 4'h4;
  localparam logic [OFFSET_W-1:0] TMR_COUNT_OFS   = 4'h8;
  localparam logic [OFFSET_W-1:0] TMR_STATUS_OFS  = 4'hC;
  localparam logic [OFFSET_W-1:0] INTC_STATUS_OFS = 4'h0;
  localparam logic [OFFSET_W-1:0] INTC_ENABLE_OFS = 4'h4;

  // response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  localparam int NUM_EXT_IRQ = 3;

  // byte lane merge for register writes
  function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] cur,
                                                   input logic [DATA_W-1:0] data,
                                                   input logic [STRB_W-1:0] strb);
    strb_merge = cur;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        strb_merge[8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

endpackage

// ==== verilog/axil_if.sv ====
`timescale 1ns/1ps

interface axil_if;

  logic                            aw_valid;
  logic                            aw_ready;
  logic [periph_pkg::OFFSET_W-1:0] aw_addr;
  logic [periph_pkg::DATA_W-1:0]   w_data;
  logic [periph_pkg::STRB_W-1:0]   w_strb;
  logic                            b_valid;
  logic                            b_ready;
  logic [1:0]                      b_resp;
  logic                            ar_valid;
  logic                            ar_ready;
  logic [periph_pkg::OFFSET_W-1:0] ar_addr;
  logic [periph_pkg::DATA_W-1:0]   r_data;
  logic [1:0]                      r_resp;
  logic                            r_valid;
  logic                            r_ready;

  // aw_valid also qualifies w_data and w_strb
  modport master (
    output aw_valid, aw_addr, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    input  aw_ready, b_valid, b_resp, ar_ready, r_data, r_resp, r_valid
  );

  modport slave (
    input  aw_valid, aw_addr, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    output aw_ready, b_valid, b_resp, ar_ready, r_data, r_resp, r_valid
  );

endinterface

// ==== verilog/axil_decoder.sv ====
`timescale 1ns/1ps

module axil_decoder (
  input  logic                          sys_clk_i,
  input  logic                          rst_i,
  input  logic [periph_pkg::ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                          s_axi_awvalid_i,
  output logic                          s_axi_awready_o,
  input  logic [periph_pkg::DATA_W-1:0] s_axi_wdata_i,
  input  logic [periph_pkg::STRB_W-1:0] s_axi_wstrb_i,
  input  logic                          s_axi_wvalid_i,
  output logic                          s_axi_wready_o,
  output logic [1:0]                    s_axi_bresp_o,
  output logic                          s_axi_bvalid_o,
  input  logic                          s_axi_bready_i,
  input  logic [periph_pkg::ADDR_W-1:0] s_axi_araddr_i,
  input  logic                          s_axi_arvalid_i,
  output logic                          s_axi_arready_o,
  output logic [periph_pkg::DATA_W-1:0] s_axi_rdata_o,
  output logic [1:0]                    s_axi_rresp_o,
  output logic                          s_axi_rvalid_o,
  input  logic                          s_axi_rready_i,
  axil_if.master                        gpio_bus,
  axil_if.master                        timer_bus,
  axil_if.master                        intc_bus
);

  localparam int NS    = periph_pkg::NUM_SLAVES;
  localparam int SEL_W = $clog2(NS);

  logic                            wr_busy, wr_fwd, wr_wait;
  logic                            rd_busy, rd_fwd, rd_wait;
  logic [SEL_W-1:0]                wr_sel, rd_sel;
  logic [SEL_W:0]                  aw_dec, ar_dec;
  logic [NS-1:0]                   wr_oh, rd_oh;
  logic [periph_pkg::OFFSET_W-1:0] wr_ofs, rd_ofs;
  logic [periph_pkg::DATA_W-1:0]   wr_data;
  logic [periph_pkg::STRB_W-1:0]   wr_strb;
  logic                            slv_aw_ready, slv_b_valid, slv_ar_ready, slv_r_valid;
  logic [1:0]                      slv_b_resp, slv_r_resp;
  logic [periph_pkg::DATA_W-1:0]   slv_r_data;

  // window match, msb set on a miss
  function automatic logic [SEL_W:0] decode(input logic [periph_pkg::ADDR_W-1:0] addr);
    logic [periph_pkg::ADDR_W-1:0] win;
    win    = addr & periph_pkg::WIN_MASK;
    decode = {1'b1, SEL_W'(0)};
    if (win == periph_pkg::GPIO_BASE) decode = {1'b0, SEL_W'(periph_pkg::SLV_GPIO)};
    if (win == periph_pkg::TIMER_BASE) decode = {1'b0, SEL_W'(periph_pkg::SLV_TIMER)};
    if (win == periph_pkg::INTC_BASE) decode = {1'b0, SEL_W'(periph_pkg::SLV_INTC)};
  endfunction

  assign aw_dec  = decode(s_axi_awaddr_i);
  assign ar_dec  = decode(s_axi_araddr_i);
  assign wr_oh   = NS'(1) << wr_sel;
  assign rd_oh   = NS'(1) << rd_sel;
  // request handed over, response not yet on the top port
  assign wr_wait = wr_busy && !wr_fwd && !s_axi_bvalid_o;
  assign rd_wait = rd_busy && !rd_fwd && !s_axi_rvalid_o;

  //**************************************************************************
  // slave side
  //**************************************************************************
  assign gpio_bus.aw_valid  = wr_fwd && wr_oh[periph_pkg::SLV_GPIO];
  assign gpio_bus.aw_addr   = wr_ofs;
  assign gpio_bus.w_data    = wr_data;
  assign gpio_bus.w_strb    = wr_strb;
  assign gpio_bus.b_ready   = wr_wait && wr_oh[periph_pkg::SLV_GPIO];
  assign gpio_bus.ar_valid  = rd_fwd && rd_oh[periph_pkg::SLV_GPIO];
  assign gpio_bus.ar_addr   = rd_ofs;
  assign gpio_bus.r_ready   = rd_wait && rd_oh[periph_pkg::SLV_GPIO];

  assign timer_bus.aw_valid = wr_fwd && wr_oh[periph_pkg::SLV_TIMER];
  assign timer_bus.aw_addr  = wr_ofs;
  assign timer_bus.w_data   = wr_data;
  assign timer_bus.w_strb   = wr_strb;
  assign timer_bus.b_ready  = wr_wait && wr_oh[periph_pkg::SLV_TIMER];
  assign timer_bus.ar_valid = rd_fwd && rd_oh[periph_pkg::SLV_TIMER];
  assign timer_bus.ar_addr  = rd_ofs;
  assign timer_bus.r_ready  = rd_wait && rd_oh[periph_pkg::SLV_TIMER];

  assign intc_bus.aw_valid  = wr_fwd && wr_oh[periph_pkg::SLV_INTC];
  assign intc_bus.aw_addr   = wr_ofs;
  assign intc_bus.w_data    = wr_data;
  assign intc_bus.w_strb    = wr_strb;
  assign intc_bus.b_ready   = wr_wait && wr_oh[periph_pkg::SLV_INTC];
  assign intc_bus.ar_valid  = rd_fwd && rd_oh[periph_pkg::SLV_INTC];
  assign intc_bus.ar_addr   = rd_ofs;
  assign intc_bus.r_ready   = rd_wait && rd_oh[periph_pkg::SLV_INTC];

  // bit order follows the slave indices
  assign slv_aw_ready = |(wr_oh & {intc_bus.aw_ready, timer_bus.aw_ready, gpio_bus.aw_ready});
  assign slv_b_valid  = |(wr_oh & {intc_bus.b_valid, timer_bus.b_valid, gpio_bus.b_valid});
  assign slv_ar_ready = |(rd_oh & {intc_bus.ar_ready, timer_bus.ar_ready, gpio_bus.ar_ready});
  assign slv_r_valid  = |(rd_oh & {intc_bus.r_valid, timer_bus.r_valid, gpio_bus.r_valid});

  assign slv_b_resp = wr_oh[periph_pkg::SLV_GPIO]  ? gpio_bus.b_resp  :
                      wr_oh[periph_pkg::SLV_TIMER] ? timer_bus.b_resp : intc_bus.b_resp;
  assign slv_r_resp = rd_oh[periph_pkg::SLV_GPIO]  ? gpio_bus.r_resp  :
                      rd_oh[periph_pkg::SLV_TIMER] ? timer_bus.r_resp : intc_bus.r_resp;
  assign slv_r_data = rd_oh[periph_pkg::SLV_GPIO]  ? gpio_bus.r_data  :
                      rd_oh[periph_pkg::SLV_TIMER] ? timer_bus.r_data : intc_bus.r_data;

  //**************************************************************************
  // write channel
  //**************************************************************************
  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      s_axi_awready_o <= 1'b0;
      s_axi_wready_o  <= 1'b0;
      s_axi_bvalid_o  <= 1'b0;
      wr_busy         <= 1'b0;
      wr_fwd          <= 1'b0;
    end else begin
      // address and data taken in the same cycle
      s_axi_awready_o <= s_axi_awvalid_i && s_axi_wvalid_i && !wr_busy && !s_axi_awready_o;
      s_axi_wready_o  <= s_axi_awvalid_i && s_axi_wvalid_i && !wr_busy && !s_axi_awready_o;
      if (s_axi_awready_o) begin
        wr_busy        <= 1'b1;
        wr_sel         <= aw_dec[SEL_W-1:0];
        wr_ofs         <= s_axi_awaddr_i[periph_pkg::OFFSET_W-1:0];
        wr_data        <= s_axi_wdata_i;
        wr_strb        <= s_axi_wstrb_i;
        wr_fwd         <= !aw_dec[SEL_W];
        // a miss never reaches a slave
        s_axi_bvalid_o <= aw_dec[SEL_W];
        s_axi_bresp_o  <= periph_pkg::RESP_DECERR;
      end
      if (wr_fwd && slv_aw_ready) begin
        wr_fwd <= 1'b0;
      end
      if (wr_wait && slv_b_valid) begin
        s_axi_bvalid_o <= 1'b1;
        s_axi_bresp_o  <= slv_b_resp;
      end
      if (s_axi_bvalid_o && s_axi_bready_i) begin
        s_axi_bvalid_o <= 1'b0;
        wr_busy        <= 1'b0;
      end
    end
  end

  //**************************************************************************
  // read channel
  //**************************************************************************
  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      s_axi_arready_o <= 1'b0;
      s_axi_rvalid_o  <= 1'b0;
      rd_busy         <= 1'b0;
      rd_fwd          <= 1'b0;
    end else begin
      s_axi_arready_o <= s_axi_arvalid_i && !rd_busy && !s_axi_arready_o;
      if (s_axi_arready_o) begin
        rd_busy        <= 1'b1;
        rd_sel         <= ar_dec[SEL_W-1:0];
        rd_ofs         <= s_axi_araddr_i[periph_pkg::OFFSET_W-1:0];
        rd_fwd         <= !ar_dec[SEL_W];
        s_axi_rvalid_o <= ar_dec[SEL_W];
        s_axi_rresp_o  <= periph_pkg::RESP_DECERR;
        s_axi_rdata_o  <= '0;
      end
      if (rd_fwd && slv_ar_ready) begin
        rd_fwd <= 1'b0;
      end
      if (rd_wait && slv_r_valid) begin
        s_axi_rvalid_o <= 1'b1;
        s_axi_rresp_o  <= slv_r_resp;
        s_axi_rdata_o  <= slv_r_data;
      end
      if (s_axi_rvalid_o && s_axi_rready_i) begin
        s_axi_rvalid_o <= 1'b0;
        rd_busy        <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/axil_gpio.sv ====
`timescale 1ns/1ps

module axil_gpio #(
  parameter int GPIO_W = 32
) (
  input  logic              sys_clk_i,
  input  logic              rst_i,
  axil_if.slave             bus,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_t_o
);

  logic [GPIO_W-1:0] gpio_meta;
  logic [GPIO_W-1:0] gpio_sync;

  // pins are asynchronous to the bus clock
  always_ff @(posedge sys_clk_i) begin
    gpio_meta <= gpio_i;
    gpio_sync <= gpio_meta;
  end

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      bus.aw_ready <= 1'b0;
      bus.b_valid  <= 1'b0;
      bus.ar_ready <= 1'b0;
      bus.r_valid  <= 1'b0;
      gpio_o       <= '0;
      gpio_t_o     <= '1;
    end else begin
      // accept one cycle after the offer
      bus.aw_ready <= bus.aw_valid && !bus.aw_ready && !bus.b_valid;
      bus.ar_ready <= bus.ar_valid && !bus.ar_ready && !bus.r_valid;
      if (bus.b_valid && bus.b_ready) begin
        bus.b_valid <= 1'b0;
      end
      if (bus.r_valid && bus.r_ready) begin
        bus.r_valid <= 1'b0;
      end
      if (bus.aw_valid && bus.aw_ready) begin
        bus.b_valid <= 1'b1;
        bus.b_resp  <= periph_pkg::RESP_OKAY;
        case (bus.aw_addr)
          periph_pkg::GPIO_DATA_OFS:
            gpio_o <= GPIO_W'(periph_pkg::strb_merge(periph_pkg::DATA_W'(gpio_o),
                                                     bus.w_data, bus.w_strb));
          periph_pkg::GPIO_TRI_OFS:
            gpio_t_o <= GPIO_W'(periph_pkg::strb_merge(periph_pkg::DATA_W'(gpio_t_o),
                                                       bus.w_data, bus.w_strb));
          default: bus.b_resp <= periph_pkg::RESP_SLVERR;
        endcase
      end
      if (bus.ar_valid && bus.ar_ready) begin
        bus.r_valid <= 1'b1;
        bus.r_resp  <= periph_pkg::RESP_OKAY;
        bus.r_data  <= '0;
        case (bus.ar_addr)
          // data reads the pins, not the output register
          periph_pkg::GPIO_DATA_OFS: bus.r_data <= periph_pkg::DATA_W'(gpio_sync);
          periph_pkg::GPIO_TRI_OFS:  bus.r_data <= periph_pkg::DATA_W'(gpio_t_o);
          default:                   bus.r_resp <= periph_pkg::RESP_SLVERR;
        endcase
      end
    end
  end

endmodule

// ==== verilog/axil_timer.sv ====
`timescale 1ns/1ps

module axil_timer (
  input  logic  sys_clk_i,
  input  logic  rst_i,
  axil_if.slave bus,
  output logic  timer_irq_o
);

  logic [periph_pkg::DATA_W-1:0] load_q;
  logic [periph_pkg::DATA_W-1:0] count_q;
  logic                          en_q;
  logic                          reload_q;
  logic                          expired_q;

  assign timer_irq_o = expired_q;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      bus.aw_ready <= 1'b0;
      bus.b_valid  <= 1'b0;
      bus.ar_ready <= 1'b0;
      bus.r_valid  <= 1'b0;
      load_q       <= '0;
      count_q      <= '0;
      en_q         <= 1'b0;
      reload_q     <= 1'b0;
      expired_q    <= 1'b0;
    end else begin
      // countdown, a bus write below takes priority
      if (en_q) begin
        if (count_q == '0) begin
          expired_q <= 1'b1;
          if (reload_q) begin
            count_q <= load_q;
          end else begin
            en_q <= 1'b0;
          end
        end else begin
          count_q <= count_q - 1'b1;
        end
      end

      bus.aw_ready <= bus.aw_valid && !bus.aw_ready && !bus.b_valid;
      bus.ar_ready <= bus.ar_valid && !bus.ar_ready && !bus.r_valid;
      if (bus.b_valid && bus.b_ready) begin
        bus.b_valid <= 1'b0;
      end
      if (bus.r_valid && bus.r_ready) begin
        bus.r_valid <= 1'b0;
      end
      if (bus.aw_valid && bus.aw_ready) begin
        bus.b_valid <= 1'b1;
        bus.b_resp  <= periph_pkg::RESP_OKAY;
        case (bus.aw_addr)
          periph_pkg::TMR_LOAD_OFS: load_q <= periph_pkg::strb_merge(load_q, bus.w_data, bus.w_strb);
          periph_pkg::TMR_CTRL_OFS: begin
            if (bus.w_strb[0]) begin
              en_q     <= bus.w_data[0];
              reload_q <= bus.w_data[1];
              // start from the load value
              if (bus.w_data[0]) count_q <= load_q;
            end
          end
          // write one to clear
          periph_pkg::TMR_STATUS_OFS: if (bus.w_strb[0] && bus.w_data[0]) expired_q <= 1'b0;
          periph_pkg::TMR_COUNT_OFS: ;
          default: bus.b_resp <= periph_pkg::RESP_SLVERR;
        endcase
      end
      if (bus.ar_valid && bus.ar_ready) begin
        bus.r_valid <= 1'b1;
        bus.r_resp  <= periph_pkg::RESP_OKAY;
        bus.r_data  <= '0;
        case (bus.ar_addr)
          periph_pkg::TMR_LOAD_OFS:   bus.r_data <= load_q;
          periph_pkg::TMR_CTRL_OFS:   bus.r_data[1:0] <= {reload_q, en_q};
          periph_pkg::TMR_COUNT_OFS:  bus.r_data <= count_q;
          periph_pkg::TMR_STATUS_OFS: bus.r_data[0] <= expired_q;
          default:                    bus.r_resp <= periph_pkg::RESP_SLVERR;
        endcase
      end
    end
  end

endmodule

// ==== verilog/irq_ctrl.sv ====
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                               sys_clk_i,
  input  logic                               rst_i,
  axil_if.slave                              bus,
  input  logic                               timer_irq_i,
  input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                               irq_o
);

  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_meta;
  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_sync;
  logic [periph_pkg::NUM_EXT_IRQ:0]   status;
  logic [periph_pkg::NUM_EXT_IRQ:0]   enable_q;

  // timer in bit 0, external lines above it
  assign status = {ext_sync, timer_irq_i};

  always_ff @(posedge sys_clk_i) begin
    ext_meta <= ext_irq_i;
    ext_sync <= ext_meta;
  end

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      bus.aw_ready <= 1'b0;
      bus.b_valid  <= 1'b0;
      bus.ar_ready <= 1'b0;
      bus.r_valid  <= 1'b0;
      enable_q     <= '0;
      irq_o        <= 1'b0;
    end else begin
      irq_o        <= |(status & enable_q);
      bus.aw_ready <= bus.aw_valid && !bus.aw_ready && !bus.b_valid;
      bus.ar_ready <= bus.ar_valid && !bus.ar_ready && !bus.r_valid;
      if (bus.b_valid && bus.b_ready) begin
        bus.b_valid <= 1'b0;
      end
      if (bus.r_valid && bus.r_ready) begin
        bus.r_valid <= 1'b0;
      end
      if (bus.aw_valid && bus.aw_ready) begin
        bus.b_valid <= 1'b1;
        bus.b_resp  <= periph_pkg::RESP_OKAY;
        case (bus.aw_addr)
          periph_pkg::INTC_ENABLE_OFS:
            if (bus.w_strb[0]) enable_q <= bus.w_data[periph_pkg::NUM_EXT_IRQ:0];
          // status reflects live sources, nothing to store
          periph_pkg::INTC_STATUS_OFS: ;
          default: bus.b_resp <= periph_pkg::RESP_SLVERR;
        endcase
      end
      if (bus.ar_valid && bus.ar_ready) begin
        bus.r_valid <= 1'b1;
        bus.r_resp  <= periph_pkg::RESP_OKAY;
        bus.r_data  <= '0;
        case (bus.ar_addr)
          periph_pkg::INTC_STATUS_OFS: bus.r_data <= periph_pkg::DATA_W'(status);
          periph_pkg::INTC_ENABLE_OFS: bus.r_data <= periph_pkg::DATA_W'(enable_q);
          default:                     bus.r_resp <= periph_pkg::RESP_SLVERR;
        endcase
      end
    end
  end

endmodule

// ==== verilog/periph_subsystem.sv ====
`timescale 1ns/1ps

module periph_subsystem #(
  parameter int GPIO_W = 32
) (
  input  logic                               sys_clk_i,
  input  logic                               rst_i,
  input  logic [periph_pkg::ADDR_W-1:0]      s_axi_awaddr_i,
  input  logic                               s_axi_awvalid_i,
  output logic                               s_axi_awready_o,
  input  logic [periph_pkg::DATA_W-1:0]      s_axi_wdata_i,
  input  logic [periph_pkg::STRB_W-1:0]      s_axi_wstrb_i,
  input  logic                               s_axi_wvalid_i,
  output logic                               s_axi_wready_o,
  output logic [1:0]                         s_axi_bresp_o,
  output logic                               s_axi_bvalid_o,
  input  logic                               s_axi_bready_i,
  input  logic [periph_pkg::ADDR_W-1:0]      s_axi_araddr_i,
  input  logic                               s_axi_arvalid_i,
  output logic                               s_axi_arready_o,
  output logic [periph_pkg::DATA_W-1:0]      s_axi_rdata_o,
  output logic [1:0]                         s_axi_rresp_o,
  output logic                               s_axi_rvalid_o,
  input  logic                               s_axi_rready_i,
  input  logic [GPIO_W-1:0]                  gpio_i,
  output logic [GPIO_W-1:0]                  gpio_o,
  output logic [GPIO_W-1:0]                  gpio_t_o,
  input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                               irq_o
);

  logic timer_irq;

  axil_if gpio_bus ();
  axil_if timer_bus ();
  axil_if intc_bus ();

  axil_decoder inst_axil_decoder (
    .sys_clk_i       (sys_clk_i),
    .rst_i           (rst_i),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .gpio_bus        (gpio_bus.master),
    .timer_bus       (timer_bus.master),
    .intc_bus        (intc_bus.master)
  );

  axil_gpio #(
    .GPIO_W (GPIO_W)
  ) inst_axil_gpio (
    .sys_clk_i (sys_clk_i),
    .rst_i     (rst_i),
    .bus       (gpio_bus.slave),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_t_o  (gpio_t_o)
  );

  axil_timer inst_axil_timer (
    .sys_clk_i   (sys_clk_i),
    .rst_i       (rst_i),
    .bus         (timer_bus.slave),
    .timer_irq_o (timer_irq)
  );

  // timer interrupt joins the external lines here
  irq_ctrl inst_irq_ctrl (
    .sys_clk_i   (sys_clk_i),
    .rst_i       (rst_i),
    .bus         (intc_bus.slave),
    .timer_irq_i (timer_irq),
    .ext_irq_i   (ext_irq_i),
    .irq_o       (irq_o)
  );

endmodule

// ==== tests/periph_subsystem_tb.sv ====
`timescale 1ns/1ps

module periph_subsystem_tb;

  localparam int GPIO_W = 32;

  logic                               sys_clk_i;
  logic                               rst_i;
  logic [periph_pkg::ADDR_W-1:0]      s_axi_awaddr_i;
  logic                               s_axi_awvalid_i;
  logic                               s_axi_awready_o;
  logic [periph_pkg::DATA_W-1:0]      s_axi_wdata_i;
  logic [periph_pkg::STRB_W-1:0]      s_axi_wstrb_i;
  logic                               s_axi_wvalid_i;
  logic                               s_axi_wready_o;
  logic [1:0]                         s_axi_bresp_o;
  logic                               s_axi_bvalid_o;
  logic                               s_axi_bready_i;
  logic [periph_pkg::ADDR_W-1:0]      s_axi_araddr_i;
  logic                               s_axi_arvalid_i;
  logic                               s_axi_arready_o;
  logic [periph_pkg::DATA_W-1:0]      s_axi_rdata_o;
  logic [1:0]                         s_axi_rresp_o;
  logic                               s_axi_rvalid_o;
  logic                               s_axi_rready_i;
  logic [GPIO_W-1:0]                  gpio_i;
  logic [GPIO_W-1:0]                  gpio_o;
  logic [GPIO_W-1:0]                  gpio_t_o;
  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq_i;
  logic                               irq_o;

  int          ops_issued;
  int          cycles;
  logic [31:0] seed;
  logic        mon_on;
  logic        bready_q, rready_q, bvalid_prev, rvalid_prev;
  logic [1:0]  bresp_prev, rresp_prev;
  logic [31:0] rdata_prev;

  // expected register contents
  logic [31:0] gpio_o_m, gpio_t_m, load_m;
  logic [3:0]  en_m;

  periph_subsystem #(
    .GPIO_W (GPIO_W)
  ) periph_subsystem_i (.*);

  always #4 sys_clk_i = ~sys_clk_i;

  function automatic logic [31:0] next_rand();
    seed      = seed * 32'd1664525 + 32'd1013904223;
    next_rand = seed;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] cur, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] mask;
    mask        = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    merge_bytes = (data & mask) | (cur & ~mask);
  endfunction

  function automatic logic in_window(input logic [31:0] a);
    logic [31:0] w;
    w         = a & periph_pkg::WIN_MASK;
    in_window = (w == periph_pkg::GPIO_BASE) || (w == periph_pkg::TIMER_BASE) ||
                (w == periph_pkg::INTC_BASE);
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure("value mismatch");
    end
  endtask

  //**************************************************************************
  // bus tasks, entered and left on a falling edge
  //**************************************************************************
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int d;
    ops_issued++;
    s_axi_awaddr_i  = addr;
    s_axi_wdata_i   = data;
    s_axi_wstrb_i   = strb;
    s_axi_awvalid_i = 1'b1;
    s_axi_wvalid_i  = 1'b1;
    do @(negedge sys_clk_i); while (!s_axi_awready_o);
    check_value("s_axi_wready_o", 1, s_axi_wready_o);
    @(negedge sys_clk_i);
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    while (!s_axi_bvalid_o) @(negedge sys_clk_i);
    resp = s_axi_bresp_o;
    d    = next_rand() % 4;
    repeat (d) @(negedge sys_clk_i);
    s_axi_bready_i = 1'b1;
    @(negedge sys_clk_i);
    s_axi_bready_i = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int d;
    ops_issued++;
    s_axi_araddr_i  = addr;
    s_axi_arvalid_i = 1'b1;
    do @(negedge sys_clk_i); while (!s_axi_arready_o);
    @(negedge sys_clk_i);
    s_axi_arvalid_i = 1'b0;
    while (!s_axi_rvalid_o) @(negedge sys_clk_i);
    data = s_axi_rdata_o;
    resp = s_axi_rresp_o;
    d    = next_rand() % 4;
    repeat (d) @(negedge sys_clk_i);
    s_axi_rready_i = 1'b1;
    @(negedge sys_clk_i);
    s_axi_rready_i = 1'b0;
  endtask

  //**************************************************************************
  // response stability and watchdog
  //**************************************************************************
  always @(posedge sys_clk_i) begin
    bready_q <= s_axi_bready_i;
    rready_q <= s_axi_rready_i;
  end

  always @(negedge sys_clk_i) begin
    if (mon_on) begin
      // response was pending and not taken at the last edge
      if (bvalid_prev && !bready_q) begin
        check_value("s_axi_bvalid_o", 1, s_axi_bvalid_o);
        check_value("s_axi_bresp_o", bresp_prev, s_axi_bresp_o);
      end
      if (rvalid_prev && !rready_q) begin
        check_value("s_axi_rvalid_o", 1, s_axi_rvalid_o);
        check_value("s_axi_rresp_o", rresp_prev, s_axi_rresp_o);
        check_value("s_axi_rdata_o", rdata_prev, s_axi_rdata_o);
      end
      if (s_axi_bvalid_o) check_value("s_axi_awready_o", 0, s_axi_awready_o);
      if (s_axi_rvalid_o) check_value("s_axi_arready_o", 0, s_axi_arready_o);
      bvalid_prev = s_axi_bvalid_o;
      bresp_prev  = s_axi_bresp_o;
      rvalid_prev = s_axi_rvalid_o;
      rresp_prev  = s_axi_rresp_o;
      rdata_prev  = s_axi_rdata_o;
    end
  end

  always @(negedge sys_clk_i) begin
    cycles++;
    if (cycles > ops_issued * 200 + 2000) begin
      stop_with_failure("timeout: the bus did not answer in time");
    end
  end

  initial begin
    logic [31:0] addr, data, rnd;
    logic [3:0]  strb;
    logic [1:0]  resp;
    int          polls;
    seed = 32'h5693a11d;
    sys_clk_i = 1'b0;
    rst_i = 1'b1;
    s_axi_awaddr_i = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i = '0;
    s_axi_wstrb_i = '0;
    s_axi_wvalid_i = 1'b0;
    s_axi_bready_i = 1'b0;
    s_axi_araddr_i = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i = 1'b0;
    gpio_i = '0;
    ext_irq_i = '0;
    ops_issued = 0;
    cycles = 0;
    mon_on = 1'b0;
    bvalid_prev = 1'b0;
    rvalid_prev = 1'b0;
    gpio_o_m = '0;
    gpio_t_m = '1;
    load_m = '0;
    en_m = '0;
    repeat (5) @(negedge sys_clk_i);
    rst_i = 1'b0;

    check_value("s_axi_bvalid_o", 0, s_axi_bvalid_o);
    check_value("s_axi_rvalid_o", 0, s_axi_rvalid_o);
    check_value("gpio_o", 0, gpio_o);
    check_value("irq_o", 0, irq_o);
    check_value("gpio_t_o", 32'hFFFF_FFFF, gpio_t_o);
    mon_on = 1'b1;

    // gpio data and tristate registers
    for (int i = 0; i < 40; i++) begin
      rnd  = next_rand();
      addr = periph_pkg::GPIO_BASE | (rnd[16] ? 32'h4 : 32'h0);
      strb = rnd[3:0];
      data = next_rand();
      bus_write(addr, data, strb, resp);
      check_value("s_axi_bresp_o", periph_pkg::RESP_OKAY, resp);
      if (rnd[16]) gpio_t_m = merge_bytes(gpio_t_m, data, strb);
      else gpio_o_m = merge_bytes(gpio_o_m, data, strb);
      check_value("gpio_o", gpio_o_m, gpio_o);
      check_value("gpio_t_o", gpio_t_m, gpio_t_o);
      bus_read(periph_pkg::GPIO_BASE | 32'h4, data, resp);
      check_value("s_axi_rresp_o", periph_pkg::RESP_OKAY, resp);
      check_value("s_axi_rdata_o", gpio_t_m, data);
      gpio_i = next_rand();
      repeat (3) @(negedge sys_clk_i);
      bus_read(periph_pkg::GPIO_BASE, data, resp);
      check_value("s_axi_rresp_o", periph_pkg::RESP_OKAY, resp);
      check_value("s_axi_rdata_o", gpio_i, data);
    end

    // known values first, so unchanged registers can be told apart
    load_m = next_rand();
    bus_write(periph_pkg::TIMER_BASE | periph_pkg::TMR_LOAD_OFS, load_m, 4'hF, resp);
    check_value("s_axi_bresp_o", periph_pkg::RESP_OKAY, resp);
    rnd  = next_rand();
    en_m = rnd[3:0];
    bus_write(periph_pkg::INTC_BASE | periph_pkg::INTC_ENABLE_OFS, {28'h0, en_m}, 4'hF, resp);
    check_value("s_axi_bresp_o", periph_pkg::RESP_OKAY, resp);
    for (int i = 0; i < 10; i++) begin
      do addr = next_rand(); while (in_window(addr));
      bus_write(addr, next_rand(), 4'hF, resp);
      check_value("s_axi_bresp_o", periph_pkg::RESP_DECERR, resp);
      do addr = next_rand(); while (in_window(addr));
      bus_read(addr, data, resp);
      check_value("s_axi_rresp_o", periph_pkg::RESP_DECERR, resp);
      check_value("s_axi_rdata_o", 0, data);
    end
    bus_write(periph_pkg::GPIO_BASE | 32'h8, next_rand(), 4'hF, resp);
    check_value("s_axi_bresp_o", periph_pkg::RESP_SLVERR, resp);
    bus_read(periph_pkg::GPIO_BASE | 32'hC, data, resp);
    check_value("s_axi_rresp_o", periph_pkg::RESP_SLVERR, resp);
    check_value("s_axi_rdata_o", 0, data);
    bus_write(periph_pkg::INTC_BASE | 32'hC, next_rand(), 4'hF, resp);
    check_value("s_axi_bresp_o", periph_pkg::RESP_SLVERR, resp);
    bus_read(periph_pkg::INTC_BASE | 32'h8, data, resp);
    check_value("s_axi_rresp_o", periph_pkg::RESP_SLVERR, resp);
    check_value("s_axi_rdata_o", 0, data);
    check_value("gpio_o", gpio_o_m, gpio_o);
    check_value("gpio_t_o", gpio_t_m, gpio_t_o);
    bus_read(periph_pkg::GPIO_BASE | periph_pkg::GPIO_TRI_OFS, data, resp);
    check_value("s_axi_rdata_o", gpio_t_m, data);
    bus_read(periph_pkg::TIMER_BASE | periph_pkg::TMR_LOAD_OFS, data, resp);
    check_value("s_axi_rdata_o", load_m, data);
    bus_read(periph_pkg::INTC_BASE | periph_pkg::INTC_ENABLE_OFS, data, resp);
    check_value("s_axi_rdata_o", {28'h0, en_m}, data);

    //************************************************************************
    // timer one-shot
    //************************************************************************
    rnd    = next_rand();
    load_m = 5 + rnd % 56;
    bus_write(periph_pkg::TIMER_BASE | periph_pkg::TMR_LOAD_OFS, load_m, 4'hF, resp);
    en_m = 4'h1;
    bus_write(periph_pkg::INTC_BASE | periph_pkg::INTC_ENABLE_OFS, 32'h1, 4'hF, resp);
    bus_write(periph_pkg::TIMER_BASE | periph_pkg::TMR_CTRL_OFS, 32'h1, 4'hF, resp);
    check_value("s_axi_bresp_o", periph_pkg::RESP_OKAY, resp);
    polls = 0;
    data  = '0;
    while (!data[0] && polls < load_m + 10) begin
      bus_read(periph_pkg::TIMER_BASE | periph_pkg::TMR_STATUS_OFS, data, resp);
      polls++;
    end
    assert (data[0]) else stop_with_failure("timer never reported expiry");
    check_value("irq_o", 1, irq_o);
    bus_read(periph_pkg::TIMER_BASE | periph_pkg::TMR_COUNT_OFS, data, resp);
    check_value("s_axi_rdata_o", 0, data);
    bus_read(periph_pkg::TIMER_BASE | periph_pkg::TMR_CTRL_OFS, data, resp);
    check_value("s_axi_rdata_o", 0, data[0]);
    bus_read(periph_pkg::INTC_BASE | periph_pkg::INTC_STATUS_OFS, data, resp);
    check_value("s_axi_rdata_o", 1, data[0]);
    bus_write(periph_pkg::TIMER_BASE | periph_pkg::TMR_STATUS_OFS, 32'h1, 4'hF, resp);
    for (int i = 0; i < 4 && irq_o; i++) @(negedge sys_clk_i);
    check_value("irq_o", 0, irq_o);

    // external lines against a random mask
    for (int i = 0; i < 30; i++) begin
      rnd       = next_rand();
      en_m      = rnd[3:0];
      ext_irq_i = rnd[10:8];
      bus_write(periph_pkg::INTC_BASE | periph_pkg::INTC_ENABLE_OFS, {28'h0, en_m}, 4'hF, resp);
      check_value("s_axi_bresp_o", periph_pkg::RESP_OKAY, resp);
      repeat (4) @(negedge sys_clk_i);
      check_value("irq_o", |({ext_irq_i, 1'b0} & en_m), irq_o);
      bus_read(periph_pkg::INTC_BASE | periph_pkg::INTC_STATUS_OFS, data, resp);
      check_value("s_axi_rdata_o", {28'h0, ext_irq_i, 1'b0}, data);
    end

    $display("Test OK");
    $finish;
  end

endmodule

// ==== periph_subsystem.f ====
verilog/periph_pkg.sv
verilog/axil_if.sv
verilog/axil_decoder.sv
verilog/axil_gpio.sv
verilog/axil_timer.sv
verilog/irq_ctrl.sv
verilog/periph_subsystem.sv
tests/periph_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, then decide from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module periph_subsystem_tb \
  -f periph_subsystem.f -o sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
